/* src/glay_mem_pkg.sv */
// Memory-side widths and request/response types
// Byte addresses only, reads only; no write data or strobes
// Requestor id is one bit, so exactly two requestors are supported
package glay_mem_pkg;

  // ----------------------------------------------------------------------
  // Widths
  // ----------------------------------------------------------------------
  localparam int addr_width     = 32;
  localparam int data_width     = 32;
  // Vertex fetch and edge fetch
  localparam int num_requestors = 2;

  // Requestor index, doubles as response tag
  typedef logic req_id_t;

  // ----------------------------------------------------------------------
  // Request formats
  // ----------------------------------------------------------------------
  // Request as presented by a requestor, id stamped by the arbiter
  typedef struct packed {
    logic [addr_width-1:0] base_address;
    logic [addr_width-1:0] address_offset;
    req_id_t               id;
  } mem_request_t;

  // Formed cache request, base plus offset already added
  typedef struct packed {
    logic [addr_width-1:0] addr;
    req_id_t               id;
  } cache_request_t;

endpackage

/* src/glay_ctrl_pkg.sv */
// Control-side constants for the cache request generator
// FIFO depth must stay a power of two, pointers wrap naturally
// Almost-full level leaves two entries for requests already in flight
package glay_ctrl_pkg;

  // ----------------------------------------------------------------------
  // Request FIFO sizing
  // ----------------------------------------------------------------------
  localparam int fifo_depth             = 8;
  localparam int fifo_ptr_width         = 3;
  // Arbiter output plus fill stage still to land
  localparam int fifo_almost_full_level = 6;

  // ----------------------------------------------------------------------
  // Generator FSM
  // ----------------------------------------------------------------------
  typedef enum logic [1:0] {
    cache_req_gen_reset,
    cache_req_gen_idle,
    // FIFO head on its way to the bus registers
    cache_req_gen_fetch,
    // Wishbone cycle open, waiting on ack
    cache_req_gen_bus_wait
  } cache_req_gen_state_t;

endpackage

/* src/mem_req_if.sv */
// Valid/ready channel carrying one read request
// Transfer on an edge with valid and ready both high
// Source holds req stable while valid is high and ready is low
`timescale 1ns/1ns

interface mem_req_if;

  // ----------------------------------------------------------------------
  // Channel signals
  // ----------------------------------------------------------------------
  logic                      valid;
  logic                      ready;
  glay_mem_pkg::mem_request_t req;

  // Requestor side, or arbiter toward the generator
  modport source (
    output valid,
    output req,
    input  ready
  );

  // Consumer side
  modport sink (
    input  valid,
    input  req,
    output ready
  );

endinterface

/* src/mem_req_arbiter.sv */
// Two-way round-robin arbiter with one registered output word
// Ready goes only to the granted requestor, and only with downstream space
// Downstream ready must not depend on valid
`timescale 1ns/1ns

module mem_req_arbiter (
  input logic     ap_clk,
  input logic     control_areset,
  mem_req_if.sink req_in [glay_mem_pkg::num_requestors],
  mem_req_if.source req_out
);

  logic [glay_mem_pkg::num_requestors-1:0] in_valid;
  logic [glay_mem_pkg::num_requestors-1:0] in_ready;
  logic [glay_mem_pkg::num_requestors-1:0] grant;
  glay_mem_pkg::mem_request_t             in_req [glay_mem_pkg::num_requestors];
  glay_mem_pkg::mem_request_t             sel_req;
  glay_mem_pkg::mem_request_t             out_req;
  glay_mem_pkg::req_id_t                  sel_id;
  glay_mem_pkg::req_id_t                  last_grant;
  logic                                   out_valid;
  logic                                   load;

  // ----------------------------------------------------------------------
  // Unpack the interface array
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < glay_mem_pkg::num_requestors; i++) begin : g_in
    assign in_valid[i]     = req_in[i].valid;
    assign in_req[i]       = req_in[i].req;
    assign req_in[i].ready = in_ready[i];
  end

  // ----------------------------------------------------------------------
  // Grant selection
  // ----------------------------------------------------------------------
  always_comb begin
    // Contention goes to whoever was not served last
    if (&in_valid) begin
      grant = last_grant ? 2'b01 : 2'b10;
    end else begin
      grant = in_valid;
    end
  end

  assign sel_id = grant[1];

  // Stamp the winner's id onto the word
  always_comb begin
    sel_req    = in_req[sel_id];
    sel_req.id = sel_id;
  end

  // Output register empties whenever downstream has space
  assign in_ready = req_out.ready ? grant : '0;
  assign load     = |in_ready;

  // ----------------------------------------------------------------------
  // Output stage
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      out_valid  <= 1'b0;
      // Requestor 0 wins the first contention
      last_grant <= 1'b1;
    end else if (load) begin
      out_valid  <= 1'b1;
      last_grant <= sel_id;
    end else if (req_out.ready) begin
      out_valid <= 1'b0;
    end
  end

  // Payload only
  always_ff @(posedge ap_clk) begin
    if (load) begin
      out_req <= sel_req;
    end
  end

  assign req_out.valid = out_valid;
  assign req_out.req   = out_req;

  // Never accept from both requestors in one cycle
  assert property (@(posedge ap_clk) disable iff (control_areset) $onehot0(in_ready));

endmodule

/* src/cache_req_fifo.sv */
// Register-array FIFO for formed cache requests
// dout is registered, valid the cycle after rd_en
// No write when full and no read when empty; callers must respect the flags
`timescale 1ns/1ns

module cache_req_fifo (
  input  logic                         ap_clk,
  input  logic                         control_areset,
  input  logic                         wr_en,
  input  glay_mem_pkg::cache_request_t din,
  input  logic                         rd_en,
  output glay_mem_pkg::cache_request_t dout,
  output logic                         empty,
  output logic                         full,
  output logic                         almost_full
);

  glay_mem_pkg::cache_request_t            mem [glay_ctrl_pkg::fifo_depth];
  logic [glay_ctrl_pkg::fifo_ptr_width-1:0] wr_ptr;
  logic [glay_ctrl_pkg::fifo_ptr_width-1:0] rd_ptr;
  // One bit wider than the pointers to hold a full count
  logic [glay_ctrl_pkg::fifo_ptr_width:0]   count;

  // ----------------------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap at the power-of-two depth
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Storage and read register
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= din;
    end
    if (rd_en) begin
      dout <= mem[rd_ptr];
    end
  end

  // Flags straight from the count
  assign empty       = (count == '0);
  assign full        = (count == (glay_ctrl_pkg::fifo_ptr_width + 1)'(glay_ctrl_pkg::fifo_depth));
  assign almost_full = (count >=
                        (glay_ctrl_pkg::fifo_ptr_width + 1)'(glay_ctrl_pkg::fifo_almost_full_level));

  // Overflow means the almost-full headroom upstream is too small
  assert property (@(posedge ap_clk) disable iff (control_areset) !(wr_en && full));
  assert property (@(posedge ap_clk) disable iff (control_areset) !(rd_en && empty));

endmodule

/* src/cache_request_generator.sv */
// Forms byte addresses, queues them, and issues Wishbone classic reads
// One bus cycle open at a time; the next pop waits for the previous ack
// Response is registered and valid one cycle after the ack is sampled
// Ready toward the arbiter is low in the first cycle after reset
`timescale 1ns/1ns

module cache_request_generator (
  input  logic                                 ap_clk,
  input  logic                                 control_areset,
  mem_req_if.sink                              req_in,
  output logic                                 wb_cyc,
  output logic                                 wb_stb,
  output logic                                 wb_we,
  output logic [glay_mem_pkg::addr_width-1:0]  wb_adr,
  input  logic [glay_mem_pkg::data_width-1:0]  wb_dat_i,
  input  logic                                 wb_ack,
  output logic                                 resp_valid,
  output glay_mem_pkg::req_id_t                resp_id,
  output logic [glay_mem_pkg::data_width-1:0]  resp_data
);

  glay_ctrl_pkg::cache_req_gen_state_t state;
  glay_ctrl_pkg::cache_req_gen_state_t next_state;
  glay_mem_pkg::cache_request_t        fill_req;
  glay_mem_pkg::cache_request_t        fifo_dout;
  glay_mem_pkg::req_id_t               bus_id;
  logic                                fill_valid;
  logic                                fifo_rd_en;
  logic                                fifo_empty;
  logic                                fifo_almost_full;

  // ----------------------------------------------------------------------
  // Fill stage
  // ----------------------------------------------------------------------
  // Space signal, independent of valid
  assign req_in.ready = (state != glay_ctrl_pkg::cache_req_gen_reset) &&
                        !fifo_almost_full;

  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      fill_valid <= 1'b0;
    end else begin
      fill_valid <= req_in.valid && req_in.ready;
    end
  end

  // Address add one cycle ahead of the FIFO write
  always_ff @(posedge ap_clk) begin
    if (req_in.valid && req_in.ready) begin
      fill_req.addr <= req_in.req.base_address + req_in.req.address_offset;
      fill_req.id   <= req_in.req.id;
    end
  end

  cache_req_fifo cache_req_fifo_i (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .wr_en          (fill_valid),
    .din            (fill_req),
    .rd_en          (fifo_rd_en),
    .dout           (fifo_dout),
    .empty          (fifo_empty),
    .full           (),
    .almost_full    (fifo_almost_full)
  );

  // ----------------------------------------------------------------------
  // Issue FSM
  // ----------------------------------------------------------------------
  // Pop only from idle
  // Head lands in fifo_dout during fetch
  assign fifo_rd_en = (state == glay_ctrl_pkg::cache_req_gen_idle) && !fifo_empty;

  always_comb begin
    next_state = state;
    case (state)
      glay_ctrl_pkg::cache_req_gen_reset:    next_state = glay_ctrl_pkg::cache_req_gen_idle;
      glay_ctrl_pkg::cache_req_gen_idle: begin
        if (!fifo_empty) begin
          next_state = glay_ctrl_pkg::cache_req_gen_fetch;
        end
      end
      glay_ctrl_pkg::cache_req_gen_fetch:    next_state = glay_ctrl_pkg::cache_req_gen_bus_wait;
      glay_ctrl_pkg::cache_req_gen_bus_wait: begin
        if (wb_ack) begin
          next_state = glay_ctrl_pkg::cache_req_gen_idle;
        end
      end
      default:                               next_state = glay_ctrl_pkg::cache_req_gen_reset;
    endcase
  end

  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      state      <= glay_ctrl_pkg::cache_req_gen_reset;
      wb_cyc     <= 1'b0;
      wb_stb     <= 1'b0;
      resp_valid <= 1'b0;
    end else begin
      state      <= next_state;
      // Response strobe is a single-cycle pulse
      resp_valid <= 1'b0;
      if (state == glay_ctrl_pkg::cache_req_gen_fetch) begin
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
      end else if (state == glay_ctrl_pkg::cache_req_gen_bus_wait && wb_ack) begin
        // Drop the cycle right after the ack edge
        wb_cyc     <= 1'b0;
        wb_stb     <= 1'b0;
        resp_valid <= 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Bus and response payload
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (state == glay_ctrl_pkg::cache_req_gen_fetch) begin
      wb_adr <= fifo_dout.addr;
      bus_id <= fifo_dout.id;
    end
    if (state == glay_ctrl_pkg::cache_req_gen_bus_wait && wb_ack) begin
      resp_data <= wb_dat_i;
      resp_id   <= bus_id;
    end
  end

  // Read-only master
  assign wb_we = 1'b0;

  // Cycle closes on the edge after the ack
  assert property (@(posedge ap_clk) disable iff (control_areset)
                   (wb_cyc && wb_ack) |=> !(wb_cyc || wb_stb));
  // Address held until the ack
  assert property (@(posedge ap_clk) disable iff (control_areset)
                   (wb_cyc && !wb_ack) |=> (wb_cyc && $stable(wb_adr)));

endmodule

/* src/glay_cache_req_top.sv */
// Cache request front end for two peer read requestors
// Requestors follow valid/ready; hold address inputs stable until accepted
// Wishbone classic master, reads only, one cycle open at a time
// Responses are tagged with the id of the requestor that asked
`timescale 1ns/1ns

module glay_cache_req_top (
  input  logic                                ap_clk,
  input  logic                                control_areset,
  // Requestor 0
  input  logic                                req0_valid,
  output logic                                req0_ready,
  input  logic [glay_mem_pkg::addr_width-1:0] req0_base_address,
  input  logic [glay_mem_pkg::addr_width-1:0] req0_address_offset,
  // Requestor 1
  input  logic                                req1_valid,
  output logic                                req1_ready,
  input  logic [glay_mem_pkg::addr_width-1:0] req1_base_address,
  input  logic [glay_mem_pkg::addr_width-1:0] req1_address_offset,
  // Wishbone master
  output logic                                wb_cyc,
  output logic                                wb_stb,
  output logic                                wb_we,
  output logic [glay_mem_pkg::addr_width-1:0] wb_adr,
  input  logic [glay_mem_pkg::data_width-1:0] wb_dat_i,
  input  logic                                wb_ack,
  // Responses
  output logic                                resp_valid,
  output glay_mem_pkg::req_id_t               resp_id,
  output logic [glay_mem_pkg::data_width-1:0] resp_data
);

  mem_req_if req_if [glay_mem_pkg::num_requestors] ();
  mem_req_if arb_if ();

  // ----------------------------------------------------------------------
  // Requestor ports onto the channels
  // ----------------------------------------------------------------------
  assign req_if[0].valid = req0_valid;
  assign req_if[0].req   = '{base_address: req0_base_address,
                             address_offset: req0_address_offset, id: 1'b0};
  assign req0_ready      = req_if[0].ready;

  assign req_if[1].valid = req1_valid;
  assign req_if[1].req   = '{base_address: req1_base_address,
                             address_offset: req1_address_offset, id: 1'b1};
  assign req1_ready      = req_if[1].ready;

  mem_req_arbiter mem_req_arbiter_i (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .req_in         (req_if),
    .req_out        (arb_if)
  );

  cache_request_generator cache_request_generator_i (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .req_in         (arb_if),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_adr         (wb_adr),
    .wb_dat_i       (wb_dat_i),
    .wb_ack         (wb_ack),
    .resp_valid     (resp_valid),
    .resp_id        (resp_id),
    .resp_data      (resp_data)
  );

endmodule

/* sim/glay_cache_req_tb.sv */
// Directed tests for the cache request front end
// Cache model answers after 0 to 7 cycles with data = address ^ 32'h5a5a_0f0f
// Inputs driven 1 ns after the rising edge, outputs sampled at the falling edge
// Bus order is checked against acceptance order, responses per requestor
`timescale 1ns/1ns

module glay_cache_req_tb;

  localparam int          clk_period      = 8;
  localparam logic [31:0] data_xor        = 32'h5a5a_0f0f;
  localparam int          total_requests  = 1 + 16 + 20 + 40;
  localparam int          watchdog_cycles = 200 * total_requests + 500;

  logic        ap_clk = 1'b0;
  logic        control_areset;
  logic [1:0]  req_valid;
  logic [1:0]  req_ready;
  logic [31:0] req_base [2];
  logic [31:0] req_offs [2];
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [31:0] wb_adr;
  logic [31:0] wb_dat_i;
  logic        wb_ack;
  logic        resp_valid;
  logic        resp_id;
  logic [31:0] resp_data;

  // Scoreboards
  logic [31:0] exp_q [2][$];
  logic [31:0] bus_q [$];
  logic        grant_log [$];
  int          resp_count [2];
  int          bus_cycles;
  bit          stall_seen;

  // Cache model state
  int          ack_fixed;
  bit          ack_random;
  int          ack_delay;
  int          ack_wait;
  bit          cycle_open;
  logic [31:0] held_adr;
  logic [31:0] lfsr_state = 32'hfe2e;

  always #(clk_period / 2) ap_clk = ~ap_clk;

  glay_cache_req_top glay_cache_req_top_i (
    .ap_clk              (ap_clk),
    .control_areset      (control_areset),
    .req0_valid          (req_valid[0]),
    .req0_ready          (req_ready[0]),
    .req0_base_address   (req_base[0]),
    .req0_address_offset (req_offs[0]),
    .req1_valid          (req_valid[1]),
    .req1_ready          (req_ready[1]),
    .req1_base_address   (req_base[1]),
    .req1_address_offset (req_offs[1]),
    .wb_cyc              (wb_cyc),
    .wb_stb              (wb_stb),
    .wb_we               (wb_we),
    .wb_adr              (wb_adr),
    .wb_dat_i            (wb_dat_i),
    .wb_ack              (wb_ack),
    .resp_valid          (resp_valid),
    .resp_id             (resp_id),
    .resp_data           (resp_data)
  );

  // ----------------------------------------------------------------------
  // Random bits and error handling
  // ----------------------------------------------------------------------
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      stop_run("Value mismatch");
    end
  endtask

  // ----------------------------------------------------------------------
  // Wishbone cache model
  // ----------------------------------------------------------------------
  always begin
    @(posedge ap_clk);
    #1;
    if (!control_areset) begin
      check_equal("wb_we", 32'd0, 32'(wb_we));
      check_equal("wb_stb_without_cyc", 32'd0, 32'(wb_stb && !wb_cyc));
      if (wb_ack) begin
        // Master must close the cycle right after the ack edge
        wb_ack = 1'b0;
        check_equal("wb_cyc", 32'd0, 32'(wb_cyc));
      end else if (wb_cyc && wb_stb) begin
        if (!cycle_open) begin
          cycle_open = 1'b1;
          ack_wait   = 0;
          ack_delay  = ack_random ? int'(take_bits(3)) : ack_fixed;
          held_adr   = wb_adr;
        end else begin
          check_equal("wb_adr", held_adr, wb_adr);
        end
        if (ack_wait >= ack_delay) begin
          if (bus_q.size() == 0) begin
            stop_run("Wishbone read issued with no accepted request");
          end else begin
            // Bus order follows acceptance order
            check_equal("wb_adr", bus_q.pop_front(), wb_adr);
            wb_dat_i   = wb_adr ^ data_xor;
            wb_ack     = 1'b1;
            cycle_open = 1'b0;
            bus_cycles++;
          end
        end else begin
          ack_wait++;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Response monitor
  // ----------------------------------------------------------------------
  always @(negedge ap_clk) begin
    if (!control_areset) begin
      if (resp_valid) begin
        if (exp_q[resp_id].size() == 0) begin
          stop_run("Response arrived for a requestor with nothing outstanding");
        end else begin
          check_equal("resp_data", exp_q[resp_id].pop_front() ^ data_xor, resp_data);
          resp_count[resp_id]++;
        end
      end
      // Requests waiting with no ready while the bus is busy
      if ((|req_valid) && !(|req_ready) && wb_cyc) begin
        stall_seen = 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Requestor driver and test tasks
  // ----------------------------------------------------------------------
  // Holds each request until accepted
  // Gaps inserts random idle cycles
  task automatic drive_stream(input int id, input int count, input logic [31:0] base,
                              input bit gaps);
    int   sent;
    logic taken;
    sent = 0;
    @(posedge ap_clk);
    #1;
    while (sent < count) begin
      if (!req_valid[id] && (!gaps || take_bits(1) == 32'd1)) begin
        req_base[id]  = base + (take_bits(4) << 12);
        req_offs[id]  = take_bits(16);
        req_valid[id] = 1'b1;
      end
      @(negedge ap_clk);
      taken = req_valid[id] && req_ready[id];
      if (taken) begin
        exp_q[id].push_back(req_base[id] + req_offs[id]);
        bus_q.push_back(req_base[id] + req_offs[id]);
        grant_log.push_back(id[0]);
        sent++;
      end
      @(posedge ap_clk);
      #1;
      if (taken) begin
        req_valid[id] = 1'b0;
      end
    end
  endtask

  task automatic wait_drain;
    while (bus_q.size() != 0 || exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
      @(negedge ap_clk);
    end
    repeat (2) @(negedge ap_clk);
  endtask

  task automatic test_reset;
    // Valids high so a stray ready would show
    req_valid = 2'b11;
    repeat (4) begin
      @(posedge ap_clk);
      #1;
      check_equal("wb_cyc", 32'd0, 32'(wb_cyc));
      check_equal("wb_stb", 32'd0, 32'(wb_stb));
      check_equal("wb_we", 32'd0, 32'(wb_we));
      check_equal("resp_valid", 32'd0, 32'(resp_valid));
      check_equal("req_ready", 32'd0, 32'(req_ready));
    end
    control_areset = 1'b0;
    // First cycle out of reset
    @(negedge ap_clk);
    check_equal("req_ready", 32'd0, 32'(req_ready));
    check_equal("wb_cyc", 32'd0, 32'(wb_cyc));
    check_equal("resp_valid", 32'd0, 32'(resp_valid));
    @(posedge ap_clk);
    #1;
    req_valid = 2'b00;
    repeat (2) @(posedge ap_clk);
  endtask

  task automatic test_single_request;
    int cycles_before;
    int resp0_before;
    int resp1_before;
    cycles_before = bus_cycles;
    resp0_before  = resp_count[0];
    resp1_before  = resp_count[1];
    ack_fixed     = 3;
    ack_random    = 1'b0;
    drive_stream(0, 1, 32'h1000_0000, 1'b0);
    wait_drain();
    check_equal("bus_cycles", cycles_before + 1, bus_cycles);
    check_equal("resp_count_0", resp0_before + 1, resp_count[0]);
    check_equal("resp_count_1", resp1_before, resp_count[1]);
  endtask

  task automatic test_fair_sharing;
    ack_fixed = 1;
    grant_log.delete();
    fork
      drive_stream(0, 8, 32'h1000_0000, 1'b0);
      drive_stream(1, 8, 32'h2000_0000, 1'b0);
    join
    wait_drain();
    check_equal("grant_count", 32'd16, grant_log.size());
    // Both always valid so every grant alternates
    for (int i = 1; i < grant_log.size(); i++) begin
      check_equal("grant_id", 32'(!grant_log[i-1]), 32'(grant_log[i]));
    end
  endtask

  task automatic test_back_pressure;
    int resp0_before;
    int resp1_before;
    resp0_before = resp_count[0];
    resp1_before = resp_count[1];
    ack_fixed    = 7;
    stall_seen   = 1'b0;
    fork
      drive_stream(0, 10, 32'h3000_0000, 1'b0);
      drive_stream(1, 10, 32'h4000_0000, 1'b0);
    join
    wait_drain();
    check_equal("stall_seen", 32'd1, 32'(stall_seen));
    check_equal("resp_count_0", resp0_before + 10, resp_count[0]);
    check_equal("resp_count_1", resp1_before + 10, resp_count[1]);
  endtask

  task automatic test_random_stream;
    int resp0_before;
    int resp1_before;
    resp0_before = resp_count[0];
    resp1_before = resp_count[1];
    ack_random   = 1'b1;
    fork
      drive_stream(0, 20, 32'h5000_0000, 1'b1);
      drive_stream(1, 20, 32'h6000_0000, 1'b1);
    join
    wait_drain();
    check_equal("resp_count_0", resp0_before + 20, resp_count[0]);
    check_equal("resp_count_1", resp1_before + 20, resp_count[1]);
  endtask

  // ----------------------------------------------------------------------
  // Main sequence and watchdog
  // ----------------------------------------------------------------------
  initial begin
    control_areset = 1'b1;
    req_valid      = 2'b00;
    req_base[0]    = 32'h0;
    req_base[1]    = 32'h0;
    req_offs[0]    = 32'h0;
    req_offs[1]    = 32'h0;
    wb_dat_i       = 32'h0;
    wb_ack         = 1'b0;
    ack_fixed      = 0;
    ack_random     = 1'b0;
    cycle_open     = 1'b0;
    stall_seen     = 1'b0;
    test_reset();
    test_single_request();
    test_fair_sharing();
    test_back_pressure();
    test_random_stream();
    $display("STATUS: PASS");
    $finish;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    stop_run("Timeout, the tests did not finish within the cycle budget");
  end

endmodule

/* glay_cache_req.f */
src/glay_mem_pkg.sv
src/glay_ctrl_pkg.sv
src/mem_req_if.sv
src/mem_req_arbiter.sv
src/cache_req_fifo.sv
src/cache_request_generator.sv
src/glay_cache_req_top.sv
sim/glay_cache_req_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the cache request front end testbench with Verilator.
# Exit status is non-zero when compilation or simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module glay_cache_req_tb \
  -f glay_cache_req.f \
  -o glay_cache_req_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit "$status"
fi

./obj_dir/glay_cache_req_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

exit 0
